// File: ddr_cfg.svh
`ifndef DDR_CFG_SVH
`define DDR_CFG_SVH

// channel count, kept a power of two so the channel is a plain slice of the line index
`define DDR_NUM_CHAN 4

// 64-byte lines held by each channel model
`define DDR_CHAN_LINES 64

// host byte address of the first memory byte
`define DDR_BASE 64'h0000_0000_8000_0000

// cycles from the edge that captures start to done
`define DDR_BURST_LAT 80   // whole 512-bit line
`define DDR_SINGLE_LAT 64  // one 64-bit word

// requests that may be outstanding between dispatch and collect
`define DDR_ORDER_DEPTH 8

// derived field widths
`define DDR_CHAN_BITS $clog2(`DDR_NUM_CHAN)    // channel select bits
`define DDR_LINE_BITS $clog2(`DDR_CHAN_LINES)  // line within a channel

// one line is eight 64-bit words
`define DDR_LINE_W 512
`define DDR_WORD_W 64

`endif

// File: ddr_chan_if.sv
`timescale 1ns/100ps

// start/done exchange between dispatcher, one channel and collector
interface ddr_chan_if
    import ddr_pkg::*;
();

    logic                   start;  // one-cycle pulse from the dispatcher
    ddr_cmd_t               cmd;    // valid while start is high
    logic                   busy;   // channel owns a request, start to ack
    logic                   done;   // latency ran out, held until ack
    logic [`DDR_LINE_W-1:0] rdata;  // valid with done
    logic                   ack;    // one-cycle pulse from the collector

    // dispatcher side, launches requests into an idle channel
    modport dispatch (
        output start,
        output cmd,
        input  busy
    );

    // the channel model itself
    modport channel (
        input  start,
        input  cmd,
        input  ack,
        output busy,
        output done,
        output rdata
    );

    // collector side, drains finished requests in issue order
    modport collect (
        input  done,
        input  rdata,
        output ack
    );

endinterface

// File: ddr_channel.sv
`timescale 1ns/100ps
`include "ddr_cfg.svh"

module ddr_channel
    import ddr_pkg::*;
(
    input  logic        clock,
    input  logic        reset_n,
    ddr_chan_if.channel bus
);

    localparam int CNT_W = $clog2(`DDR_BURST_LAT);  // burst is the longer wait

    logic                   busy_q;   // request owned from start to ack
    logic                   done_q;   // latency expired and result held
    logic                   run;      // counting phase
    logic                   finish;   // last counting cycle with the memory access
    logic [CNT_W-1:0]       cnt;      // cycles since the start edge
    logic [CNT_W-1:0]       last;     // terminal count for this request
    ddr_cmd_t               cmd_q;    // latched request
    logic [`DDR_LINE_W-1:0] rdata_q;  // response line

    // channel storage with one 512-bit entry per line
    logic [`DDR_LINE_W-1:0] mem [`DDR_CHAN_LINES];

    assign run  = busy_q && !done_q;
    assign last = cmd_q.burst ? CNT_W'(`DDR_BURST_LAT - 1)
                              : CNT_W'(`DDR_SINGLE_LAT - 1);
    // done is set on the edge where cnt would reach the latency
    assign finish = run && (cnt == last);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt    <= '0;
        end else if (bus.start) begin
            busy_q <= 1'b1;  // busy from the edge after start
            cnt    <= '0;
        end else if (bus.ack) begin
            busy_q <= 1'b0;  // response taken and channel free again
            done_q <= 1'b0;
        end else if (finish) begin
            done_q <= 1'b1;  // holds until ack even under back-pressure
        end else if (run) begin
            cnt <= cnt + 1'b1;
        end
    end

    // latch the command while start is high
    always_ff @(posedge clock) begin
        if (bus.start) begin
            cmd_q <= bus.cmd;
        end
    end

    // all eight words move in one cycle
    always_ff @(posedge clock) begin
        if (finish) begin
            if (cmd_q.write) begin
                if (cmd_q.burst) begin
                    mem[cmd_q.line] <= cmd_q.wdata;
                end else begin
                    // only the low word of wdata counts for a single write
                    mem[cmd_q.line][{cmd_q.word, 6'd0} +: `DDR_WORD_W] <=
                        cmd_q.wdata[`DDR_WORD_W-1:0];
                end
                rdata_q <= '0;  // writes answer with zero data
            end else if (cmd_q.burst) begin
                rdata_q <= mem[cmd_q.line];  // word 0 lands in the low bits
            end else begin
                rdata_q <= {{(`DDR_LINE_W - `DDR_WORD_W){1'b0}},
                            mem[cmd_q.line][{cmd_q.word, 6'd0} +: `DDR_WORD_W]};
            end
        end
    end

    assign bus.busy  = busy_q;
    assign bus.done  = done_q;
    assign bus.rdata = rdata_q;

    // a start has to find the channel idle
    a_start_when_idle : assert property (
        @(posedge clock) disable iff (!reset_n)
        bus.start |-> !bus.busy
    ) else $error("channel: start while busy");

    // ack only against a held result
    a_ack_with_done : assert property (
        @(posedge clock) disable iff (!reset_n)
        bus.ack |-> bus.done
    ) else $error("channel: ack without done");

endmodule

// File: ddr_collect.sv
`timescale 1ns/100ps
`include "ddr_cfg.svh"

module ddr_collect
    import ddr_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   issue_valid,
    input  ddr_chan_id_t           issue_chan,
    output logic                   order_full,
    ddr_chan_if.collect            chan [`DDR_NUM_CHAN],
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output logic [`DDR_LINE_W-1:0] rsp_rdata
);

    localparam int PTR_W = $clog2(`DDR_ORDER_DEPTH);  // depth is a power of two

    ddr_chan_id_t             order_q [`DDR_ORDER_DEPTH];  // channel of each issue, oldest first
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [PTR_W:0]           count;                       // entries in the order queue
    ddr_chan_id_t             head;                        // channel owed the next response
    logic [`DDR_NUM_CHAN-1:0] chan_done;
    logic [`DDR_LINE_W-1:0]   chan_rdata [`DDR_NUM_CHAN];
    logic                     pop;                         // host takes the response

    assign head       = order_q[rd_ptr];
    assign order_full = (count == (PTR_W + 1)'(`DDR_ORDER_DEPTH));

    // response shows up the same cycle the head channel raises done
    assign rsp_valid = (count != '0) && chan_done[head];
    assign rsp_rdata = chan_rdata[head];
    assign pop       = rsp_valid && rsp_ready;

    for (genvar c = 0; c < `DDR_NUM_CHAN; c++) begin : g_chan
        assign chan_done[c]  = chan[c].done;
        assign chan_rdata[c] = chan[c].rdata;
        assign chan[c].ack   = pop && (head == ddr_chan_id_t'(c));  // same-cycle ack
    end

    // queue entries, no clear needed since count guards the head
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            order_q[wr_ptr] <= issue_chan;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (issue_valid) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at the depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop in one cycle leave the count alone
            case ({issue_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // dispatcher stalls on full, so an issue here with no room means a lost response
    a_no_push_full : assert property (
        @(posedge clock) disable iff (!reset_n)
        issue_valid |-> !order_full
    ) else $error("collect: order queue pushed while full");

endmodule

// File: ddr_dispatch.sv
`timescale 1ns/100ps
`include "ddr_cfg.svh"

module ddr_dispatch
    import ddr_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset_n,
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic                   cmd_write,
    input  logic                   cmd_burst,
    input  logic [63:0]            cmd_addr,
    input  logic [`DDR_LINE_W-1:0] cmd_wdata,
    ddr_chan_if.dispatch           chan [`DDR_NUM_CHAN],
    output logic                   issue_valid,
    output ddr_chan_id_t           issue_chan,
    input  logic                   order_full
);

    ddr_addr_u                offs;       // rebased address
    ddr_chan_id_t             tgt;        // channel the presented command maps to
    logic [`DDR_NUM_CHAN-1:0] chan_busy;  // busy flags gathered from the channels
    logic [`DDR_NUM_CHAN-1:0] start_q;    // registered start pulses with at most one set
    ddr_cmd_t                 cmd_q;      // command shared by all channels and sampled on start
    logic                     fire;       // host transfer this cycle

    // addresses past the modelled size wrap as the upper line index bits drop out
    assign offs.flat = cmd_addr - `DDR_BASE;
    assign tgt       = offs.dec.line_idx[`DDR_CHAN_BITS-1:0];  // line interleave

    // accept only if the target is idle, not about to start, and order has room
    assign cmd_ready = !chan_busy[tgt] && !start_q[tgt] && !order_full;
    assign fire      = cmd_valid && cmd_ready;

    // collector records the issue on the transfer edge itself
    assign issue_valid = fire;
    assign issue_chan  = tgt;

    // start lands in the cycle after the transfer
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            start_q <= '0;
        end else begin
            start_q <= '0;
            if (fire) begin
                start_q[tgt] <= 1'b1;
            end
        end
    end

    // payload is only looked at by the channel whose start is high
    always_ff @(posedge clock) begin
        if (fire) begin
            cmd_q.write <= cmd_write;
            cmd_q.burst <= cmd_burst;
            cmd_q.line  <= offs.dec.line_idx[`DDR_CHAN_BITS +: `DDR_LINE_BITS];
            cmd_q.word  <= offs.dec.word_sel;  // a burst ignores this
            cmd_q.wdata <= cmd_wdata;
        end
    end

    for (genvar c = 0; c < `DDR_NUM_CHAN; c++) begin : g_chan
        assign chan[c].start = start_q[c];
        assign chan[c].cmd   = cmd_q;
        assign chan_busy[c]  = chan[c].busy;

        // busy is checked at the transfer and again one cycle later at the channel
        a_start_idle : assert property (
            @(posedge clock) disable iff (!reset_n)
            start_q[c] |-> !chan_busy[c]
        ) else $error("dispatch: start to busy channel %0d", c);
    end

endmodule

// File: ddr_pkg.sv
`include "ddr_cfg.svh"

package ddr_pkg;

    // channel number, picked from the low bits of the line index
    typedef logic [`DDR_CHAN_BITS-1:0] ddr_chan_id_t;

    // rebased byte address, seen flat or split into line, word and byte
    typedef union packed {
        logic [63:0] flat;           // offset from the memory base
        struct packed {
            logic [57:0] line_idx;   // 64-byte line, low bits select the channel
            logic [2:0]  word_sel;   // 64-bit word within the line
            logic [2:0]  byte_sel;   // byte in the word, not used by the model
        } dec;
    } ddr_addr_u;

    // command as handed to one channel
    typedef struct packed {
        logic                        write;  // 1 write, 0 read
        logic                        burst;  // 1 whole line, 0 one word
        logic [`DDR_LINE_BITS-1:0]   line;   // line within the channel
        logic [2:0]                  word;   // word in the line, single access only
        logic [`DDR_LINE_W-1:0]      wdata;  // word 0 in the low 64 bits
    } ddr_cmd_t;

endpackage

// File: run.sh
#!/usr/bin/env bash
# build and run the DDR model testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sim_ddr \
    -f tb.f \
    -o sim_ddr

./obj_dir/sim_ddr 2>&1 | tee "$LOG"

if grep -q "TEST FAILED" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
if ! grep -q "TEST PASSED" "$LOG"; then
    echo "simulation ended without a result, see $LOG"
    exit 1
fi

// File: sim_ddr_top.sv
`timescale 1ns/100ps
`include "ddr_cfg.svh"

module sim_ddr_top
    import ddr_pkg::*;
(
    input  logic                   clock,
    input  logic                   reset_n,
    // command port, valid/ready
    input  logic                   cmd_valid,
    output logic                   cmd_ready,
    input  logic                   cmd_write,
    input  logic                   cmd_burst,
    input  logic [63:0]            cmd_addr,   // byte address from DDR_BASE up
    input  logic [`DDR_LINE_W-1:0] cmd_wdata,
    // response port, valid/ready, one per command
    output logic                   rsp_valid,
    input  logic                   rsp_ready,
    output logic [`DDR_LINE_W-1:0] rsp_rdata
);

    logic         issue_valid;  // dispatcher to collector, one issue per transfer
    ddr_chan_id_t issue_chan;
    logic         order_full;   // collector back to dispatcher

    // one exchange per channel
    ddr_chan_if chan_bus [`DDR_NUM_CHAN] ();

    ddr_dispatch u_dispatch (
        .clock       (clock),
        .reset_n     (reset_n),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_write   (cmd_write),
        .cmd_burst   (cmd_burst),
        .cmd_addr    (cmd_addr),
        .cmd_wdata   (cmd_wdata),
        .chan        (chan_bus),
        .issue_valid (issue_valid),
        .issue_chan  (issue_chan),
        .order_full  (order_full)
    );

    // identical channel models, lines interleaved across them
    for (genvar g = 0; g < `DDR_NUM_CHAN; g++) begin : g_chan
        ddr_channel u_chan (
            .clock   (clock),
            .reset_n (reset_n),
            .bus     (chan_bus[g])
        );
    end

    ddr_collect u_collect (
        .clock       (clock),
        .reset_n     (reset_n),
        .issue_valid (issue_valid),
        .issue_chan  (issue_chan),
        .order_full  (order_full),
        .chan        (chan_bus),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .rsp_rdata   (rsp_rdata)
    );

endmodule

// File: tb.f
+incdir+.
ddr_pkg.sv
ddr_chan_if.sv
ddr_dispatch.sv
ddr_channel.sv
ddr_collect.sv
sim_ddr_top.sv
tb_sim_ddr.sv

// File: tb_sim_ddr.sv
`timescale 1ns/100ps
`include "ddr_cfg.svh"

module tb_sim_ddr;

    localparam int MEM_LINES = `DDR_NUM_CHAN * `DDR_CHAN_LINES;  // 64-byte lines in total
    localparam int NUM_REQ   = 33;                               // requests over all tests
    localparam int TIMEOUT   = NUM_REQ * (`DDR_BURST_LAT + 20) + 400;  // 200-cycle stall inside

    logic                   clock;
    logic                   reset_n;
    logic                   cmd_valid;
    logic                   cmd_ready;
    logic                   cmd_write;
    logic                   cmd_burst;
    logic [63:0]            cmd_addr;
    logic [`DDR_LINE_W-1:0] cmd_wdata;
    logic                   rsp_valid;
    logic                   rsp_ready;
    logic [`DDR_LINE_W-1:0] rsp_rdata;

    logic [63:0]            ref_mem [MEM_LINES * 8];  // reference memory with one entry per word
    logic [`DDR_LINE_W-1:0] exp_q [$];                // expected responses in issue order
    bit                     single_q [$];             // 1 where the response is a single read
    string                  cur_test;
    int                     errors = 0;
    int                     checks = 0;

    sim_ddr_top uut (.*);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;  // 10 ns period
    end

    // watchdog sized from the request count
    initial begin
        repeat (TIMEOUT) @(posedge clock);
        $display("timeout: the DDR model stopped answering during %s", cur_test);
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [`DDR_LINE_W-1:0] rand_line();
        logic [`DDR_LINE_W-1:0] v;
        for (int i = 0; i < `DDR_LINE_W / 32; i++) begin
            v[i*32 +: 32] = $urandom();
        end
        return v;
    endfunction

    // host byte address of a word with the line counted across all channels
    function automatic logic [63:0] word_addr(input int line, input int word);
        return `DDR_BASE + 64'(line) * 64 + 64'(word) * 8;
    endfunction

    task automatic check_line(input logic [`DDR_LINE_W-1:0] exp,
                              input logic [`DDR_LINE_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail %s: expected %h actual %h", cur_test, exp, act);
        end
    endtask

    task automatic check_word(input logic [`DDR_WORD_W-1:0] exp,
                              input logic [`DDR_LINE_W-1:0] act);
        checks++;
        if (act[`DDR_WORD_W-1:0] !== exp) begin
            errors++;
            $display("Fail %s: expected %h actual %h", cur_test, exp, act[`DDR_WORD_W-1:0]);
        end
        if (act[`DDR_LINE_W-1:`DDR_WORD_W] !== '0) begin
            errors++;  // single read must leave the upper words at zero
            $display("Fail %s: expected %h actual %h", cur_test,
                     {(`DDR_LINE_W - `DDR_WORD_W){1'b0}}, act[`DDR_LINE_W-1:`DDR_WORD_W]);
        end
    endtask

    // one command through valid/ready with the reference updated at the transfer
    task automatic send_cmd(input logic wr, input logic bst, input logic [63:0] addr,
                            input logic [`DDR_LINE_W-1:0] wdata);
        logic [63:0]            off;
        logic [`DDR_LINE_W-1:0] exp;
        int                     gl;
        int                     wi;
        if (clock !== 1'b0) @(negedge clock);
        cmd_valid = 1'b1;
        cmd_write = wr;
        cmd_burst = bst;
        cmd_addr  = addr;
        cmd_wdata = wdata;
        #1;
        while (!cmd_ready) begin  // held stable until accepted
            @(negedge clock);
            #1;
        end
        @(posedge clock);          // transfer edge
        off = addr - `DDR_BASE;
        gl  = int'((off >> 6) % MEM_LINES);  // wraps past the modelled size
        wi  = int'(off[5:3]);
        exp = '0;                  // writes answer with zero
        for (int w = 0; w < 8; w++) begin
            if (wr && bst) ref_mem[gl*8 + w] = wdata[w*64 +: 64];
            else if (!wr && bst) exp[w*64 +: 64] = ref_mem[gl*8 + w];
        end
        if (wr && !bst) ref_mem[gl*8 + wi] = wdata[63:0];
        if (!wr && !bst) exp[63:0] = ref_mem[gl*8 + wi];
        exp_q.push_back(exp);
        single_q.push_back(!wr && !bst);
        @(negedge clock);
        cmd_valid = 1'b0;
    endtask

    // take n responses and compare them in issue order
    task automatic drain(input int n);
        logic [`DDR_LINE_W-1:0] got;
        logic [`DDR_LINE_W-1:0] exp;
        bit                     single;
        for (int i = 0; i < n; i++) begin
            if (clock !== 1'b0) @(negedge clock);
            rsp_ready = 1'b1;
            #1;
            while (!rsp_valid) begin
                @(negedge clock);
                #1;
            end
            got = rsp_rdata;
            @(posedge clock);
            @(negedge clock);
            rsp_ready = 1'b0;
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: a response came back with no request outstanding", cur_test);
            end else begin
                exp    = exp_q.pop_front();
                single = single_q.pop_front();
                if (single) check_word(exp[63:0], got);
                else check_line(exp, got);
            end
        end
    endtask

    task automatic test_idle_after_reset();
        cur_test = "idle_after_reset";
        repeat (20) begin
            @(negedge clock);
            #1;
            checks++;
            if (rsp_valid) begin
                errors++;
                $display("%s: rsp_valid went high before any command", cur_test);
            end
        end
    endtask

    task automatic test_burst_rw();
        cur_test = "burst_rw";
        for (int l = 0; l < 8; l++) begin  // two lines on every channel
            send_cmd(1'b1, 1'b1, word_addr(l, 0), rand_line());
            drain(1);
            send_cmd(1'b0, 1'b1, word_addr(l, 0), '0);
            drain(1);
        end
    endtask

    task automatic test_single_word();
        cur_test = "single_word";
        send_cmd(1'b1, 1'b1, word_addr(9, 0), rand_line());
        drain(1);
        send_cmd(1'b1, 1'b0, word_addr(9, 5), rand_line());  // upper words of wdata ignored
        drain(1);
        send_cmd(1'b0, 1'b0, word_addr(9, 5), '0);
        drain(1);
        send_cmd(1'b0, 1'b1, word_addr(9, 0), '0);  // other seven words untouched
        drain(1);
    endtask

    task automatic test_unaligned_burst();
        cur_test = "unaligned_burst";
        send_cmd(1'b0, 1'b1, word_addr(5, 0) + 64'h2b, '0);  // word and byte bits set
        drain(1);
        send_cmd(1'b0, 1'b1, word_addr(MEM_LINES + 2, 3), '0);  // wraps onto line 2
        drain(1);
    endtask

    task automatic test_overlap_order();
        time t0;
        cur_test = "overlap_order";
        t0 = $time;
        for (int l = 0; l < 4; l++) begin  // one read per channel
            send_cmd(1'b0, 1'b1, word_addr(l, 0), '0);
        end
        drain(4);
        checks++;
        if (($time - t0) / 10 > 2 * `DDR_BURST_LAT) begin
            errors++;
            $display("%s: the four reads did not overlap, took %0t", cur_test, $time - t0);
        end
    endtask

    task automatic test_backpressure();
        cur_test = "backpressure";
        for (int l = 4; l < 8; l++) begin
            send_cmd(1'b0, 1'b1, word_addr(l, 0), '0);
        end
        fork
            send_cmd(1'b0, 1'b1, word_addr(0, 0), '0);  // channel 0 again and has to stall
            begin
                repeat (200) begin
                    @(negedge clock);
                    #2;
                    checks++;
                    if (cmd_ready) begin
                        errors++;
                        $display("%s: cmd_ready high while channel 0 holds its result",
                                 cur_test);
                    end
                end
                checks++;
                if (!rsp_valid) begin
                    errors++;
                    $display("%s: the held response was dropped", cur_test);
                end
                drain(5);
            end
        join
    endtask

    task automatic test_write_rsp();
        cur_test = "write_rsp";
        send_cmd(1'b1, 1'b1, word_addr(10, 0), rand_line());
        send_cmd(1'b1, 1'b0, word_addr(11, 3), rand_line());
        drain(2);
    endtask

    initial begin
        void'($urandom(3433));
        reset_n   = 1'b0;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_burst = 1'b0;
        cmd_addr  = '0;
        cmd_wdata = '0;
        rsp_ready = 1'b0;
        cur_test  = "reset";
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset_n = 1'b1;
        test_idle_after_reset();
        test_burst_rw();
        test_single_word();
        test_unaligned_burst();
        test_overlap_order();
        test_backpressure();
        test_write_rsp();
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d responses never came back", exp_q.size());
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
